// ==== design/sr_pkg.sv ====
`default_nettype none

package sr_pkg;

    localparam int data_width   = 8;
    localparam int in_channels  = 3;
    localparam int kernel_taps  = 9;
    localparam int out_channels = 3;

    // Term t = tap * in_channels + input channel
    localparam int num_terms    = kernel_taps * in_channels;

    // Lane 1 pads its last step with a zero term
    localparam int lane_steps   = (num_terms + 1) / 2;

    // Holds 27 * 128 * 255 plus bias with room to spare
    localparam int acc_width    = 22;

    typedef logic [data_width-1:0] sample_t;

    typedef sample_t [num_terms-1:0] window_t;

    typedef sample_t [out_channels-1:0] pixel_t;

    typedef logic signed [acc_width-1:0] acc_t;

    typedef struct packed {
        logic                         is_bias;
        logic [1:0]                   out_ch;
        logic [4:0]                   term;
        logic signed [data_width-1:0] value;
    } coef_weight_t;

    typedef struct packed {
        logic                         is_bias;
        logic [1:0]                   out_ch;
        logic [4:0]                   unused;
        logic signed [data_width-1:0] value;
    } coef_bias_t;

    // is_bias picks the view
    typedef union packed {
        coef_weight_t weight;
        coef_bias_t   bias;
    } coef_word_u;

endpackage

`default_nettype wire

// ==== design/lane_if.sv ====
`default_nettype none

interface lane_if;

    import sr_pkg::*;

    logic       start;
    logic [1:0] out_ch;
    acc_t       partial;
    logic       partial_valid;

    modport lane (
        input  start,
        output out_ch,
        output partial,
        output partial_valid
    );

    modport combiner (
        output start,
        input  out_ch,
        input  partial,
        input  partial_valid
    );

endinterface

`default_nettype wire

// ==== design/window_buffer.sv ====
`default_nettype none

module window_buffer #(
    parameter int IN_DEPTH = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            window_valid,
    input  sr_pkg::window_t window,
    output sr_pkg::window_t head,
    output logic            nonempty,
    input  logic            pop,
    output logic            window_credit
);

    import sr_pkg::*;

    localparam int ptr_w = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
    localparam int cnt_w = $clog2(IN_DEPTH + 1);
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(IN_DEPTH - 1);

    window_t          slots [IN_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
        if (p == last_slot) begin
            return '0;
        end
        return p + ptr_w'(1);
    endfunction

    // Source only sends while holding a credit, so a push never finds it full
    always_ff @(posedge clk) begin
        if (window_valid) begin
            slots[wr_ptr] <= window;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (window_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + cnt_w'(window_valid) - cnt_w'(pop);
        end
    end

    assign head     = slots[rd_ptr];
    assign nonempty = (count != '0);

    // One credit back per retired window
    assign window_credit = pop;

endmodule

`default_nettype wire

// ==== design/mac_lane.sv ====
`default_nettype none

module mac_lane #(
    parameter int LANE = 0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               coef_valid,
    input  sr_pkg::coef_word_u coef_word,
    input  sr_pkg::window_t    head,
    lane_if.lane               lane
);

    import sr_pkg::*;

    localparam logic       lane_bit  = 1'(LANE);
    localparam logic [3:0] last_step = 4'(lane_steps - 1);
    localparam logic [1:0] last_ch   = 2'(out_channels - 1);

    logic signed [data_width-1:0] weights [out_channels][lane_steps];

    coef_weight_t                 wr;
    logic                         running;
    logic [3:0]                   step;
    logic [1:0]                   ch;
    acc_t                         acc;
    logic [4:0]                   term_idx;
    sample_t                      sample;
    logic signed [data_width-1:0] weight;
    acc_t                         term_prod;

    assign wr = coef_word.weight;

    // Only this lane's parity is kept, packed at term / 2
    always_ff @(posedge clk) begin
        if (coef_valid && !wr.is_bias && (wr.term[0] == lane_bit) &&
            (wr.term < 5'(num_terms)) && (wr.out_ch < 2'(out_channels))) begin
            weights[wr.out_ch][wr.term[4:1]] <= wr.value;
        end
    end

    assign term_idx = {step, lane_bit};

    // Padding term 27 has no sample and no stored weight
    always_comb begin
        if (term_idx < 5'(num_terms)) begin
            sample = head[term_idx];
            weight = weights[ch][step];
        end else begin
            sample = '0;
            weight = '0;
        end
    end

    // Signed weight times unsigned sample
    assign term_prod = weight * $signed({1'b0, sample});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            running <= 1'b0;
            step    <= '0;
            ch      <= '0;
            acc     <= '0;
        end else if (lane.start) begin
            running <= 1'b1;
            step    <= '0;
            ch      <= '0;
            acc     <= '0;
        end else if (running) begin
            if (step == last_step) begin
                step <= '0;
                acc  <= '0;
                if (ch == last_ch) begin
                    running <= 1'b0;
                end else begin
                    ch <= ch + 2'd1;
                end
            end else begin
                step <= step + 4'd1;
                acc  <= acc + term_prod;
            end
        end
    end

    // Last step's product folds in here rather than in acc
    assign lane.partial       = acc + term_prod;
    assign lane.partial_valid = running && (step == last_step);
    assign lane.out_ch        = ch;

endmodule

`default_nettype wire

// ==== design/pixel_combiner.sv ====
`default_nettype none

module pixel_combiner #(
    parameter int OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               coef_valid,
    input  sr_pkg::coef_word_u coef_word,
    input  logic               nonempty,
    output logic               pop,
    lane_if.combiner           even,
    lane_if.combiner           odd,
    output logic               pixel_valid,
    output sr_pkg::pixel_t     pixel,
    input  logic               pixel_credit
);

    import sr_pkg::*;

    localparam int cred_w = $clog2(OUT_CREDITS + 1);
    localparam logic [1:0] last_ch = 2'(out_channels - 1);

    logic signed [data_width-1:0] bias [out_channels];

    coef_bias_t        bw;
    logic              busy;
    logic              launch;
    logic              can_start;
    logic [cred_w-1:0] credits;
    logic              lanes_valid;
    logic [1:0]        ch;
    acc_t              sum;
    sample_t           clamped;

    assign bw = coef_word.bias;

    always_ff @(posedge clk) begin
        if (coef_valid && bw.is_bias && (bw.out_ch < 2'(out_channels))) begin
            bias[bw.out_ch] <= bw.value;
        end
    end

    // One window in flight, and only with a pixel credit in hand
    assign can_start = !busy && nonempty && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            launch      <= 1'b0;
            pixel_valid <= 1'b0;
            credits     <= cred_w'(OUT_CREDITS);
        end else begin
            launch <= can_start;
            if (can_start) begin
                busy <= 1'b1;
            end else if (pixel_valid) begin
                busy <= 1'b0;
            end
            pixel_valid <= lanes_valid && (ch == last_ch);
            credits     <= credits - cred_w'(pixel_valid) + cred_w'(pixel_credit);
        end
    end

    assign even.start = launch;
    assign odd.start  = launch;

    // Both lanes finish a channel together
    assign lanes_valid = even.partial_valid && odd.partial_valid &&
                         (even.out_ch == odd.out_ch);
    assign ch          = even.out_ch;

    assign sum = even.partial + odd.partial + bias[ch];

    always_comb begin
        if (sum[acc_width-1]) begin
            clamped = '0;
        end else if (sum > acc_t'(255)) begin
            clamped = 8'hff;
        end else begin
            clamped = sum[data_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (lanes_valid) begin
            pixel[ch] <= clamped;
        end
    end

    // Window retires with its pixel
    assign pop = pixel_valid;

endmodule

`default_nettype wire

// ==== design/sr_conv_top.sv ====
`default_nettype none

module sr_conv_top #(
    parameter int IN_DEPTH    = 2,
    parameter int OUT_CREDITS = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               window_valid,
    input  sr_pkg::window_t    window,
    output logic               window_credit,
    input  logic               coef_valid,
    input  sr_pkg::coef_word_u coef_word,
    output logic               pixel_valid,
    output sr_pkg::pixel_t     pixel,
    input  logic               pixel_credit
);

    import sr_pkg::*;

    window_t head;
    logic    nonempty;
    logic    pop;

    lane_if lane_even ();
    lane_if lane_odd ();

    window_buffer #(
        .IN_DEPTH (IN_DEPTH)
    ) u_window_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .window_valid  (window_valid),
        .window        (window),
        .head          (head),
        .nonempty      (nonempty),
        .pop           (pop),
        .window_credit (window_credit)
    );

    // Even terms
    mac_lane #(
        .LANE (0)
    ) u_lane_even (
        .clk        (clk),
        .rst_n      (rst_n),
        .coef_valid (coef_valid),
        .coef_word  (coef_word),
        .head       (head),
        .lane       (lane_even)
    );

    // Odd terms
    mac_lane #(
        .LANE (1)
    ) u_lane_odd (
        .clk        (clk),
        .rst_n      (rst_n),
        .coef_valid (coef_valid),
        .coef_word  (coef_word),
        .head       (head),
        .lane       (lane_odd)
    );

    pixel_combiner #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_pixel_combiner (
        .clk          (clk),
        .rst_n        (rst_n),
        .coef_valid   (coef_valid),
        .coef_word    (coef_word),
        .nonempty     (nonempty),
        .pop          (pop),
        .even         (lane_even),
        .odd          (lane_odd),
        .pixel_valid  (pixel_valid),
        .pixel        (pixel),
        .pixel_credit (pixel_credit)
    );

endmodule

`default_nettype wire

// ==== tb/sr_conv_assertions.sv ====
`default_nettype none

module sr_conv_assertions (
    input wire       clk,
    input wire       rst_n,
    input wire       pixel_valid,
    input wire       pop,
    input wire       nonempty,
    input wire [7:0] credits,
    input wire       even_valid,
    input wire       odd_valid
);

    // A pixel always spends a credit the combiner holds
    credit_held: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid |-> credits != 8'd0)
        else $error("pixel_valid with no output credit left");

    pixel_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pixel_valid |=> !pixel_valid)
        else $error("pixel_valid held longer than one cycle");

    pop_from_filled: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> nonempty)
        else $error("pop with the window buffer empty");

    lanes_in_step: assert property (@(posedge clk) disable iff (!rst_n)
        even_valid == odd_valid)
        else $error("lane partial_valid pulses do not coincide");

endmodule

bind pixel_combiner sr_conv_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .pixel_valid (pixel_valid),
    .pop         (pop),
    .nonempty    (nonempty),
    .credits     (8'(credits)),
    .even_valid  (even.partial_valid),
    .odd_valid   (odd.partial_valid)
);

`default_nettype wire

// ==== tb/sr_conv_tb.sv ====
`default_nettype none

module sr_conv_tb;

    import sr_pkg::*;

    localparam int in_depth    = 2;
    localparam int out_credits = 2;
    // About 25 windows at under 100 cycles each, plus coefficient loads and margin
    localparam int max_cycles  = 20000;

    logic       clk;
    logic       rst_n;
    logic       window_valid;
    window_t    window;
    logic       window_credit;
    logic       coef_valid;
    coef_word_u coef_word;
    logic       pixel_valid;
    pixel_t     pixel;
    logic       pixel_credit;

    int     seed = 520;
    int     cycle = 0;
    int     pass_count = 0;
    int     fail_count = 0;
    int     in_credits = in_depth;
    bit     hold_credits = 1'b0;
    int     weights_m [out_channels][num_terms];
    int     bias_m [out_channels];
    pixel_t exp_q [$];
    pixel_t got_q [$];
    int     due_q [$];

    sr_conv_top #(
        .IN_DEPTH    (in_depth),
        .OUT_CREDITS (out_credits)
    ) dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .window_valid  (window_valid),
        .window        (window),
        .window_credit (window_credit),
        .coef_valid    (coef_valid),
        .coef_word     (coef_word),
        .pixel_valid   (pixel_valid),
        .pixel         (pixel),
        .pixel_credit  (pixel_credit)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Pixel monitor, input credit count and run limit
    always @(posedge clk) begin
        cycle++;
        if (pixel_valid) begin
            got_q.push_back(pixel);
            due_q.push_back(cycle + 2);
        end
        if (window_credit) begin
            in_credits++;
        end
        // A window is retired in the cycle its pixel leaves
        if (rst_n) begin
            assert (window_credit === pixel_valid) else begin
                $display("CHECK FAILED window_credit: expected 0x%h, actual 0x%h",
                         pixel_valid, window_credit);
                fail_count++;
            end
        end
        if (cycle >= max_cycles) begin
            $display("Timeout: run reached %0d cycles without finishing", cycle);
            $display("sim failed");
            $finish;
        end
    end

    // Consumer returns one credit per pixel once it is due
    always @(negedge clk) begin
        pixel_credit = 1'b0;
        if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle) begin
            pixel_credit = 1'b1;
            void'(due_q.pop_front());
        end
    end

    function automatic pixel_t expected_pixel(input window_t w);
        pixel_t p;
        int     s;
        for (int c = 0; c < out_channels; c++) begin
            s = bias_m[c];
            for (int t = 0; t < num_terms; t++) begin
                s += weights_m[c][t] * int'(w[t]);
            end
            if (s < 0) begin
                p[c] = 8'h00;
            end else if (s > 255) begin
                p[c] = 8'hff;
            end else begin
                p[c] = 8'(s);
            end
        end
        return p;
    endfunction

    function automatic window_t random_window();
        window_t w;
        for (int t = 0; t < num_terms; t++) begin
            w[t] = 8'($random(seed));
        end
        return w;
    endfunction

    task automatic clear_coefs(input int w);
        for (int c = 0; c < out_channels; c++) begin
            bias_m[c] = 0;
            for (int t = 0; t < num_terms; t++) begin
                weights_m[c][t] = w;
            end
        end
    endtask

    task automatic randomize_coefs();
        for (int c = 0; c < out_channels; c++) begin
            bias_m[c] = int'($signed(8'($random(seed))));
            for (int t = 0; t < num_terms; t++) begin
                weights_m[c][t] = int'($signed(8'($random(seed))));
            end
        end
    endtask

    // Writes every weight and bias of the model, one word per cycle
    task automatic load_coefs();
        coef_word_u cw;
        for (int c = 0; c < out_channels; c++) begin
            for (int t = 0; t < num_terms; t++) begin
                cw.weight.is_bias = 1'b0;
                cw.weight.out_ch  = 2'(c);
                cw.weight.term    = 5'(t);
                cw.weight.value   = 8'(weights_m[c][t]);
                coef_word  = cw;
                coef_valid = 1'b1;
                @(negedge clk);
            end
            cw.bias.is_bias = 1'b1;
            cw.bias.out_ch  = 2'(c);
            cw.bias.unused  = '0;
            cw.bias.value   = 8'(bias_m[c]);
            coef_word = cw;
            @(negedge clk);
        end
        coef_valid = 1'b0;
    endtask

    task automatic send_window(input window_t w);
        while (in_credits == 0) begin
            @(negedge clk);
        end
        window_valid = 1'b1;
        window       = w;
        in_credits--;
        exp_q.push_back(expected_pixel(w));
        @(negedge clk);
        window_valid = 1'b0;
    endtask

    task automatic check_pixels();
        pixel_t got;
        pixel_t exp;
        while (got_q.size() < exp_q.size()) begin
            @(negedge clk);
        end
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            got = got_q.pop_front();
            assert (got === exp) begin
                pass_count++;
            end else begin
                $display("CHECK FAILED pixel: expected 0x%h, actual 0x%h", exp, got);
                fail_count++;
            end
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic test_weight_load();
        int fails = fail_count;
        clear_coefs(0);
        weights_m[0][4]  = 1;
        weights_m[1][13] = 1;
        weights_m[2][26] = 1;
        load_coefs();
        repeat (3) send_window(random_window());
        check_pixels();
        $display("test weight load finished with %0d errors", fail_count - fails);
    endtask

    task automatic test_clamp();
        int fails = fail_count;
        clear_coefs(127);
        load_coefs();
        send_window('1);
        send_window(random_window());
        check_pixels();
        clear_coefs(-128);
        load_coefs();
        send_window('1);
        send_window(random_window());
        check_pixels();
        $display("test clamp finished with %0d errors", fail_count - fails);
    endtask

    task automatic test_bias_only();
        int fails = fail_count;
        clear_coefs(0);
        bias_m[0] = 100;
        bias_m[1] = -5;
        load_coefs();
        repeat (3) send_window(random_window());
        check_pixels();
        $display("test bias only finished with %0d errors", fail_count - fails);
    endtask

    task automatic test_backpressure();
        int fails = fail_count;
        randomize_coefs();
        load_coefs();
        @(posedge clk);
        hold_credits = 1'b1;
        @(negedge clk);
        repeat (out_credits + in_depth) send_window(random_window());
        repeat (300) @(negedge clk);
        assert (got_q.size() == out_credits && in_credits == 0) begin
            pass_count++;
        end else begin
            $display("Back-pressure failed: %0d pixels out and %0d input credits left",
                     got_q.size(), in_credits);
            fail_count++;
        end
        @(posedge clk);
        hold_credits = 1'b0;
        @(negedge clk);
        check_pixels();
        $display("test back-pressure finished with %0d errors", fail_count - fails);
    endtask

    task automatic test_random_traffic();
        int fails = fail_count;
        randomize_coefs();
        load_coefs();
        repeat (15) send_window(random_window());
        check_pixels();
        $display("test random traffic finished with %0d errors", fail_count - fails);
    endtask

    initial begin
        rst_n        = 1'b0;
        window_valid = 1'b0;
        window       = '0;
        coef_valid   = 1'b0;
        coef_word    = '0;
        pixel_credit = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_weight_load();
        test_clamp();
        test_bias_only();
        test_backpressure();
        test_random_traffic();
        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/sr_pkg.sv
design/lane_if.sv
design/window_buffer.sv
design/mac_lane.sv
design/pixel_combiner.sv
design/sr_conv_top.sv
tb/sr_conv_assertions.sv
tb/sr_conv_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module sr_conv_tb \
    -o sr_conv_sim &&
./obj_dir/sr_conv_sim > sim.log 2>&1 || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
